/* hw/bus_config.svh */
// memory map bases and RAM depth
// I/O window offsets, byte addresses
// CPU clock enable ratio against CLK96
`ifndef BUS_CONFIG_SVH
`define BUS_CONFIG_SVH

`define BUS_RAM_BASE  24'h208000  // work RAM, 32 KB
`define BUS_RAM_WORDS 16384
`define BUS_GCU_BASE  24'h400000
`define BUS_IO_BASE   24'h500000

`define IO_PLAYERS    8'h00
`define IO_SYSTEM     8'h02
`define IO_DIPS       8'h04
`define IO_VSTATUS    8'h06
`define IO_LATCH3     8'h10
`define IO_LATCH4     8'h12
`define IO_LATCH1_W   8'h14
`define IO_LATCH2_W   8'h16
`define IO_EEPROM_R   8'h18
`define IO_EEPROM_W   8'h1E
`define IO_OBJBANK    8'hC0  // whole C0..CF block

`define CEN_DIV       6  // 96 MHz down to 16 MHz

`endif

/* hw/bus_map_pkg.sv */
// address, data word and RAM index types
// byte lane strobes
// decoded region and access FSM state enums
`include "bus_config.svh"

package bus_map_pkg;

    typedef logic [23:0] bus_addr_t;  // byte address
    typedef logic [15:0] bus_word_t;
    typedef logic [$clog2(`BUS_RAM_WORDS)-1:0] ram_index_t;
    typedef logic [1:0]  lane_t;      // bit 1 upper byte, bit 0 lower byte

    typedef enum logic [1:0] {
        region_none,
        region_ram,
        region_gcu,
        region_io
    } region_e;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_cen,   // holds the access until the next cen
        st_access,     // slaves present read data
        st_read_data,  // rvalid up
        st_respond     // bvalid up
    } access_state_e;

endpackage

/* hw/board_io_pkg.sv */
// sound latch byte, GCU command mask and object bank slot types
// bit positions inside the GCU command mask
package board_io_pkg;

    typedef logic [7:0] latch_t;
    typedef logic [6:0] gcu_op_t;
    typedef logic [2:0] obj_slot_t;

    // gcu_op_t bits
    localparam int gcu_objbank_wr  = 6;
    localparam int gcu_set_ram_ptr = 5;
    localparam int gcu_read_ram_l  = 4;
    localparam int gcu_read_ram_h  = 3;
    localparam int gcu_write_ram   = 2;
    localparam int gcu_write_reg   = 1;
    localparam int gcu_select_reg  = 0;

endpackage

/* hw/cpu_bus_if.sv */
// single access bus from the AXI front end to the slaves
// master and slave modports
interface cpu_bus_if;
    import bus_map_pkg::*;

    bus_addr_t addr;
    region_e   region;
    bus_word_t wdata;
    lane_t     lanes;
    logic      wr;         // one cycle, on cen
    logic      rd;         // one cycle, on cen
    bus_word_t ram_rdata;  // valid the cycle after rd
    bus_word_t io_rdata;   // registered on rd

    modport master (
        output addr, region, wdata, lanes, wr, rd,
        input  ram_rdata, io_rdata
    );

    modport slave (
        input  addr, region, wdata, lanes, wr, rd,
        output ram_rdata, io_rdata
    );

endinterface

/* hw/cen_divider.sv */
// CPU clock enable, one CLK96 cycle in every CEN_DIV
`include "bus_config.svh"

module cen_divider (
    input  logic CLK96,
    input  logic RESET96,
    output logic cen
);

    localparam int cnt_w = $clog2(`CEN_DIV);

    logic [cnt_w-1:0] count;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            count <= '0;
            cen   <= 1'b0;
        end else begin
            if (count == cnt_w'(`CEN_DIV - 1)) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
            cen <= (count == cnt_w'(`CEN_DIV - 1));  // marks the wrap
        end
    end

endmodule

/* hw/access_fsm.sv */
// AXI4-Lite slave front end standing in for the CPU strobes
// region decode, one wr or rd pulse per transaction on cen
// read data capture and response generation
`include "bus_config.svh"

module access_fsm (
    input  logic                  CLK96,
    input  logic                  RESET96,
    input  logic                  cen,
    input  bus_map_pkg::bus_addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  bus_map_pkg::bus_addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    cpu_bus_if.master             bus
);
    import bus_map_pkg::*;

    access_state_e state;
    logic          is_wr;
    logic          take_wr;
    logic          take_rd;
    bus_word_t     rdata_q;

    function automatic region_e decode(input bus_addr_t a);
        if (a[23:15] == 9'(`BUS_RAM_BASE >> 15))
            return region_ram;     // 208000..20FFFF
        if (a[23:8] == 16'(`BUS_GCU_BASE >> 8))
            return region_gcu;
        if (a[23:8] == 16'(`BUS_IO_BASE >> 8))
            return region_io;
        return region_none;
    endfunction

    // aw and w only complete together; writes win over reads
    assign awready = (state == st_idle) && (awvalid == wvalid);
    assign wready  = awready;
    assign arready = (state == st_idle) && !awvalid && !wvalid;
    assign take_wr = (state == st_idle) && awvalid && wvalid;
    assign take_rd = (state == st_idle) && arvalid && !awvalid && !wvalid;

    // access cycle lands on cen itself
    assign bus.wr = (state == st_wait_cen) && cen && is_wr;
    assign bus.rd = (state == st_wait_cen) && cen && !is_wr;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:      if (take_wr || take_rd) state <= st_wait_cen;
                st_wait_cen:  if (cen) state <= is_wr ? st_respond : st_access;
                st_access:    state <= st_read_data;
                st_read_data: if (rready) state <= st_idle;
                st_respond:   if (bready) state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        if (take_wr) begin
            bus.addr   <= awaddr;
            bus.region <= decode(awaddr);
            bus.wdata  <= wdata[15:0];
            bus.lanes  <= wstrb[1:0];  // UDS, LDS
            is_wr      <= 1'b1;
        end else if (take_rd) begin
            bus.addr   <= araddr;
            bus.region <= decode(araddr);
            bus.lanes  <= 2'b11;
            is_wr      <= 1'b0;
        end
        if (state == st_access) begin
            case (bus.region)
                region_ram:             rdata_q <= bus.ram_rdata;
                region_gcu, region_io:  rdata_q <= bus.io_rdata;
                default:                rdata_q <= '0;  // unmapped
            endcase
        end
    end

    assign bvalid = (state == st_respond);
    assign rvalid = (state == st_read_data);
    assign bresp  = 2'b00;  // always OKAY
    assign rresp  = 2'b00;
    assign rdata  = {16'h0000, rdata_q};

endmodule

/* hw/work_ram.sv */
// 16K x 16 work RAM with two byte lanes
// synchronous read, data one cycle after rd
`include "bus_config.svh"

module work_ram (
    input logic       CLK96,
    cpu_bus_if.slave  bus
);
    import bus_map_pkg::*;

    logic [1:0][7:0] mem [`BUS_RAM_WORDS];
    ram_index_t      idx;
    logic            sel;

    assign idx = bus.addr[14:1];  // word index inside the 32 KB window
    assign sel = (bus.region == region_ram);

    always_ff @(posedge CLK96) begin
        if (sel && bus.wr) begin
            for (int i = 0; i < 2; i++) begin
                if (bus.lanes[i])
                    mem[idx][i] <= bus.wdata[8*i +: 8];  // untouched lane keeps its byte
            end
        end
        if (sel && bus.rd)
            bus.ram_rdata <= mem[idx];
    end

endmodule

/* hw/io_ports.sv */
// cabinet, DIP and video status read ports
// sound latch and EEPROM read back, GCU read data path
// sound latch write registers with NMI pulse
// EEPROM control register, updated on cen
`include "bus_config.svh"

module io_ports (
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  logic                   cen,
    cpu_bus_if.slave               bus,
    input  logic [9:0]             joystick1,  // active low
    input  logic [9:0]             joystick2,
    input  logic [3:0]             start_button,
    input  logic [3:0]             coin_input,
    input  logic                   service,
    input  logic                   dip_test,
    input  logic [7:0]             dipsw_a,
    input  logic [7:0]             dipsw_b,
    input  logic [7:0]             dipsw_c,
    input  logic                   hsync,
    input  logic                   vsync,
    input  logic                   fblank,
    input  logic [8:0]             vcount,
    input  board_io_pkg::latch_t   soundlatch3,
    input  board_io_pkg::latch_t   soundlatch4,
    input  bus_map_pkg::bus_word_t gcu_dout,
    input  logic                   eeprom_sdo,
    output board_io_pkg::latch_t   soundlatch,
    output board_io_pkg::latch_t   soundlatch2,
    output logic                   nmi,
    output logic                   eeprom_sclk,
    output logic                   eeprom_sdi,
    output logic                   eeprom_scs,
    output logic                   z80_bus_request
);
    import bus_map_pkg::*;
    import board_io_pkg::*;

    logic [7:0] offset;
    logic       io_sel;
    logic       io_rd;
    logic       gcu_rd;
    logic       latch1_wr;
    logic       latch2_wr;
    logic       eeprom_wr;
    bus_word_t  rd_value;

    // game wants active high, bits reordered
    function automatic logic [7:0] player_byte(input logic [9:0] joy);
        return {1'b0, ~joy[6], ~joy[5], ~joy[4], ~joy[0], ~joy[1], ~joy[2], ~joy[3]};
    endfunction

    assign offset    = bus.addr[7:0];
    assign io_sel    = (bus.region == region_io);
    assign io_rd     = io_sel && bus.rd;
    assign gcu_rd    = (bus.region == region_gcu) && bus.rd;
    assign latch1_wr = io_sel && bus.wr && bus.lanes[0] && (offset == `IO_LATCH1_W);
    assign latch2_wr = io_sel && bus.wr && bus.lanes[0] && (offset == `IO_LATCH2_W);
    assign eeprom_wr = io_sel && bus.wr && cen && (offset == `IO_EEPROM_W);

    assign nmi = latch1_wr || latch2_wr;  // one cycle, the access cycle

    always_comb begin
        case (offset)
            `IO_PLAYERS:  rd_value = {player_byte(joystick2), player_byte(joystick1)};
            `IO_SYSTEM:   rd_value = {dipsw_c, 1'b0, ~start_button[1], ~start_button[0],
                                      ~coin_input[1], ~coin_input[0], ~dip_test, 1'b0,
                                      ~service};
            `IO_DIPS:     rd_value = {dipsw_b, dipsw_a};
            `IO_VSTATUS:  rd_value = {hsync, vsync, 5'b11111, fblank,
                                      vcount[8] ? 8'hFF : vcount[7:0]};  // clamp past 255
            `IO_LATCH3:   rd_value = {8'h00, soundlatch3};
            `IO_LATCH4:   rd_value = {8'h00, soundlatch4};
            `IO_EEPROM_R: rd_value = {11'h000, eeprom_sdo, 3'b000, z80_bus_request};
            default:      rd_value = '0;
        endcase
    end

    always_ff @(posedge CLK96) begin
        if (gcu_rd)
            bus.io_rdata <= gcu_dout;
        else if (io_rd)
            bus.io_rdata <= rd_value;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            soundlatch      <= '0;
            soundlatch2     <= '0;
            eeprom_sclk     <= 1'b0;
            eeprom_sdi      <= 1'b0;
            eeprom_scs      <= 1'b0;
            z80_bus_request <= 1'b0;
        end else begin
            if (latch1_wr)
                soundlatch <= bus.wdata[7:0];
            if (latch2_wr)
                soundlatch2 <= bus.wdata[7:0];
            if (eeprom_wr) begin
                z80_bus_request <= bus.wdata[4];
                eeprom_sclk     <= bus.wdata[3];
                eeprom_sdi      <= bus.wdata[2];
                eeprom_scs      <= bus.wdata[0];
            end
        end
    end

endmodule

/* hw/gcu_strobes.sv */
// GCU command strobes from bus accesses to the GCU window
// object bank write from the I/O window, with its slot
// strobes hold until the GCU acknowledges
`include "bus_config.svh"

module gcu_strobes (
    input  logic                     CLK96,
    input  logic                     RESET96,
    cpu_bus_if.slave                 bus,
    input  logic                     gcu_ack,
    output board_io_pkg::gcu_op_t    gcu_op,
    output board_io_pkg::obj_slot_t  obj_slot
);
    import bus_map_pkg::*;
    import board_io_pkg::*;

    logic    gcu_wr;
    logic    gcu_rd;
    logic    bank_wr;
    gcu_op_t set_mask;

    assign gcu_wr  = (bus.region == region_gcu) && bus.wr;
    assign gcu_rd  = (bus.region == region_gcu) && bus.rd;
    assign bank_wr = (bus.region == region_io) && bus.wr &&
                     (bus.addr[7:4] == 4'(`IO_OBJBANK >> 4));

    always_comb begin
        set_mask = '0;
        if (gcu_wr) begin
            case (bus.addr[3:0])
                4'h0:       set_mask[gcu_write_reg]   = 1'b1;
                4'h4:       set_mask[gcu_select_reg]  = 1'b1;
                4'h8, 4'hA: set_mask[gcu_write_ram]   = 1'b1;
                4'hC:       set_mask[gcu_set_ram_ptr] = 1'b1;
                default:    ;
            endcase
        end
        if (gcu_rd) begin
            case (bus.addr[3:0])
                4'h8:    set_mask[gcu_read_ram_h] = 1'b1;
                4'hA:    set_mask[gcu_read_ram_l] = 1'b1;
                default: ;
            endcase
        end
        if (bank_wr)
            set_mask[gcu_objbank_wr] = 1'b1;
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96)
            gcu_op <= '0;
        else if (gcu_wr || gcu_rd || bank_wr)
            gcu_op <= gcu_op | set_mask;  // a new access beats the ack
        else if (gcu_ack)
            gcu_op <= '0;
    end

    always_ff @(posedge CLK96) begin
        if (bank_wr)
            obj_slot <= bus.addr[3:1];
    end

endmodule

/* hw/bakraid_bus_top.sv */
// main CPU bus glue top level
// AXI4-Lite host port, cabinet, video, GCU, sound and EEPROM pins
// clock enable, access FSM, work RAM, I/O ports and GCU strobes
module bakraid_bus_top (
    input  logic                     CLK96,
    input  logic                     RESET96,
    input  bus_map_pkg::bus_addr_t   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [31:0]              wdata,
    input  logic [3:0]               wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  bus_map_pkg::bus_addr_t   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [31:0]              rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic [9:0]               joystick1,
    input  logic [9:0]               joystick2,
    input  logic [3:0]               start_button,
    input  logic [3:0]               coin_input,
    input  logic                     service,
    input  logic                     dip_test,
    input  logic [7:0]               dipsw_a,
    input  logic [7:0]               dipsw_b,
    input  logic [7:0]               dipsw_c,
    input  logic                     hsync,
    input  logic                     vsync,
    input  logic                     fblank,
    input  logic [8:0]               vcount,
    input  board_io_pkg::latch_t     soundlatch3,
    input  board_io_pkg::latch_t     soundlatch4,
    input  bus_map_pkg::bus_word_t   gcu_dout,
    input  logic                     eeprom_sdo,
    output board_io_pkg::latch_t     soundlatch,
    output board_io_pkg::latch_t     soundlatch2,
    output logic                     nmi,
    output logic                     eeprom_sclk,
    output logic                     eeprom_sdi,
    output logic                     eeprom_scs,
    output logic                     z80_bus_request,
    input  logic                     gcu_ack,
    output board_io_pkg::gcu_op_t    gcu_op,
    output board_io_pkg::obj_slot_t  obj_slot
);

    logic cen;

    cpu_bus_if bus ();

    cen_divider u_cen (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .cen     (cen)
    );

    access_fsm u_fsm (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .cen     (cen),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .bus     (bus.master)
    );

    work_ram u_ram (
        .CLK96 (CLK96),
        .bus   (bus.slave)
    );

    io_ports u_io (
        .CLK96           (CLK96),
        .RESET96         (RESET96),
        .cen             (cen),
        .bus             (bus.slave),
        .joystick1       (joystick1),
        .joystick2       (joystick2),
        .start_button    (start_button),
        .coin_input      (coin_input),
        .service         (service),
        .dip_test        (dip_test),
        .dipsw_a         (dipsw_a),
        .dipsw_b         (dipsw_b),
        .dipsw_c         (dipsw_c),
        .hsync           (hsync),
        .vsync           (vsync),
        .fblank          (fblank),
        .vcount          (vcount),
        .soundlatch3     (soundlatch3),
        .soundlatch4     (soundlatch4),
        .gcu_dout        (gcu_dout),
        .eeprom_sdo      (eeprom_sdo),
        .soundlatch      (soundlatch),
        .soundlatch2     (soundlatch2),
        .nmi             (nmi),
        .eeprom_sclk     (eeprom_sclk),
        .eeprom_sdi      (eeprom_sdi),
        .eeprom_scs      (eeprom_scs),
        .z80_bus_request (z80_bus_request)
    );

    gcu_strobes u_gcu (
        .CLK96    (CLK96),
        .RESET96  (RESET96),
        .bus      (bus.slave),
        .gcu_ack  (gcu_ack),
        .gcu_op   (gcu_op),
        .obj_slot (obj_slot)
    );

endmodule

/* testbench/tb_bakraid_bus.sv */
// testbench for the main CPU bus glue
// clock, reset, AXI4-Lite host driver with random ready stalls
// work RAM model, trace player, value checks and watchdog
`include "bus_config.svh"

module tb_bakraid_bus;

    localparam int clk_period      = 4;
    localparam int reset_cycles    = 10;
    localparam int cycles_per_line = 200;

    logic        CLK96 = 1'b0;
    logic        RESET96;
    logic [23:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [23:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [9:0]  joystick1;
    logic [9:0]  joystick2;
    logic [3:0]  start_button;
    logic [3:0]  coin_input;
    logic        service;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic [7:0]  dipsw_c;
    logic        hsync;
    logic        vsync;
    logic        fblank;
    logic [8:0]  vcount;
    logic [7:0]  soundlatch3;
    logic [7:0]  soundlatch4;
    logic [15:0] gcu_dout;
    logic        eeprom_sdo;
    logic [7:0]  soundlatch;
    logic [7:0]  soundlatch2;
    logic        nmi;
    logic        eeprom_sclk;
    logic        eeprom_sdi;
    logic        eeprom_scs;
    logic        z80_bus_request;
    logic        gcu_ack;
    logic [6:0]  gcu_op;
    logic [2:0]  obj_slot;

    logic [31:0] lfsr = 32'he90f_96a6;
    logic [15:0] ram_model [`BUS_RAM_WORDS];
    int          nmi_count = 0;
    int          nmi_mark  = 0;
    string       trace_lines [$];
    bit          trace_loaded = 1'b0;

    bakraid_bus_top dut (.*);

    always #(clk_period / 2) CLK96 = ~CLK96;

    always @(negedge CLK96) begin
        if (nmi)
            nmi_count <= nmi_count + 1;  // pulses seen so far
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("FAILED at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // low lane writes to either sound latch pulse the sound CPU NMI
    function automatic logic latch_write(input logic [23:0] addr, input logic [1:0] strb);
        return strb[0] && (addr[23:8] == 16'(`BUS_IO_BASE >> 8)) &&
               (addr[7:0] == `IO_LATCH1_W || addr[7:0] == `IO_LATCH2_W);
    endfunction

    task automatic take_bits(input int count, output logic [15:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[14:0], lfsr[0]};  // one step per bit
        end
    endtask

    task automatic drive_write(input logic [23:0] addr, input logic [15:0] data,
                               input logic [1:0] strb);
        logic [15:0] stall;
        @(posedge CLK96);
        #1;
        awaddr   = addr;
        wdata    = {16'h0000, data};
        wstrb    = {2'b00, strb};
        awvalid  = 1'b1;
        wvalid   = 1'b1;
        nmi_mark = nmi_count;
        @(negedge CLK96);
        while (!(awready && wready)) @(negedge CLK96);
        @(posedge CLK96);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge CLK96);
        while (!bvalid) @(negedge CLK96);
        compare_value("bresp", 32'h0, {30'h0, bresp});
        take_bits(2, stall);
        repeat (stall) @(posedge CLK96);
        @(posedge CLK96);
        #1;
        bready = 1'b1;
        @(posedge CLK96);  // bvalid and bready meet here
        #1;
        bready = 1'b0;
    endtask

    task automatic drive_read(input logic [23:0] addr, output logic [31:0] data);
        logic [15:0] stall;
        @(posedge CLK96);
        #1;
        araddr  = addr;
        arvalid = 1'b1;
        @(negedge CLK96);
        while (!arready) @(negedge CLK96);
        @(posedge CLK96);
        #1;
        arvalid = 1'b0;
        @(negedge CLK96);
        while (!rvalid) @(negedge CLK96);
        compare_value("rresp", 32'h0, {30'h0, rresp});
        take_bits(2, stall);
        repeat (stall) @(posedge CLK96);
        @(posedge CLK96);
        #1;
        rready = 1'b1;
        @(negedge CLK96);
        data = rdata;  // sampled after the stall
        @(posedge CLK96);
        #1;
        rready = 1'b0;
    endtask

    // input groups packed as the trace data column gives them
    task automatic apply_input(input logic [7:0] sel, input logic [31:0] value);
        @(posedge CLK96);
        #1;
        case (sel)
            8'h00: {joystick2, joystick1} = value[19:0];
            8'h01: {dipsw_c, start_button, coin_input, dip_test, service} = value[17:0];
            8'h02: {dipsw_b, dipsw_a} = value[15:0];
            8'h03: {hsync, vsync, fblank, vcount} = value[11:0];
            8'h04: {soundlatch4, soundlatch3} = value[15:0];
            8'h05: gcu_dout = value[15:0];
            8'h06: eeprom_sdo = value[0];
            default: ;
        endcase
    endtask

    task automatic check_output(input logic [7:0] sel, input logic [31:0] expected);
        case (sel)
            8'h00: compare_value("soundlatch2,soundlatch", expected,
                                 {16'h0, soundlatch2, soundlatch});
            8'h01: compare_value("z80_bus_request,eeprom_sclk,eeprom_sdi,eeprom_scs",
                                 expected,
                                 {28'h0, z80_bus_request, eeprom_sclk, eeprom_sdi, eeprom_scs});
            8'h02: compare_value("gcu_op", expected, {25'h0, gcu_op});
            8'h03: compare_value("obj_slot", expected, {29'h0, obj_slot});
            8'h04: compare_value("nmi", expected, {31'h0, nmi_count != nmi_mark});
            default: ;
        endcase
    endtask

    task automatic pulse_ack();
        @(posedge CLK96);
        #1;
        gcu_ack = 1'b1;
        @(posedge CLK96);
        #1;
        gcu_ack = 1'b0;
    endtask

    initial begin
        wait (trace_loaded);
        #((trace_lines.size() * cycles_per_line + reset_cycles) * clk_period);
        abort_run("timeout: the trace did not finish within its cycle budget");
    end

    initial begin
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [23:0] addr;
        logic [31:0] data;
        logic [1:0]  strb;
        logic [7:0]  sel;
        logic [31:0] exp_v;
        logic [15:0] rnd;
        logic [31:0] rd;
        logic [13:0] idx;

        RESET96 = 1'b1;
        {awaddr, awvalid, wdata, wstrb, wvalid, bready} = '0;
        {araddr, arvalid, rready, gcu_ack} = '0;
        joystick1    = '1;  // released
        joystick2    = '1;
        start_button = '1;
        coin_input   = '1;
        service      = 1'b1;
        dip_test     = 1'b1;
        {dipsw_a, dipsw_b, dipsw_c} = '0;
        {hsync, vsync, fblank, vcount} = '0;
        {soundlatch3, soundlatch4, gcu_dout, eeprom_sdo} = '0;

        fd = $fopen("testbench/bus_trace.txt", "r");
        if (fd == 0)
            abort_run("cannot open the trace file testbench/bus_trace.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#")
                trace_lines.push_back(line);
        end
        $fclose(fd);
        trace_loaded = 1'b1;

        repeat (reset_cycles) @(posedge CLK96);
        #1;
        RESET96 = 1'b0;

        foreach (trace_lines[n]) begin
            if ($sscanf(trace_lines[n], "%c %h %h %h %h %h",
                        op, addr, data, strb, sel, exp_v) != 6)
                abort_run($sformatf("trace line %0d has the wrong number of fields", n + 1));
            case (op)
                "F": begin
                    take_bits(16, rnd);
                    drive_write(addr, rnd, strb);
                    idx = addr[14:1];
                    if (strb[0])
                        ram_model[idx][7:0] = rnd[7:0];
                    if (strb[1])
                        ram_model[idx][15:8] = rnd[15:8];
                end
                "M": begin
                    drive_read(addr, rd);
                    compare_value("rdata", {16'h0000, ram_model[addr[14:1]]}, rd);
                end
                "R": begin
                    apply_input(sel, data);
                    drive_read(addr, rd);
                    compare_value("rdata", exp_v, rd);
                end
                "W": begin
                    drive_write(addr, data[15:0], strb);
                    check_output(sel, exp_v);
                    compare_value("nmi", {31'h0, latch_write(addr, strb)},
                                  {31'h0, nmi_count != nmi_mark});
                end
                "A": begin
                    pulse_ack();
                    check_output(sel, exp_v);
                end
                "C": check_output(sel, exp_v);
                default: abort_run($sformatf("trace line %0d has an unknown operation", n + 1));
            endcase
        end

        $display("Test passed");
        $finish;
    end

endmodule

/* testbench/bus_trace.txt */
# columns, hex: op addr data strb sel expect; F ram write, M ram check, R read, W write, A ack, C check
# R drives input group sel with data first; W, A and C compare output group sel with expect
F 208000 0 3 ff 0
F 208000 0 1 ff 0
M 208000 0 0 ff 0
F 208000 0 2 ff 0
M 208000 0 0 ff 0
F 208000 0 0 ff 0
M 208000 0 0 ff 0
F 20fffe 0 3 ff 0
M 20fffe 0 0 ff 0
M 208000 0 0 ff 0
R 500000 edffe 0 00 4108
R 500002 297b6 0 01 a531
R 500004 3c96 0 02 3c96
R 500006 a7b 0 03 bf7b
R 500006 505 0 03 7eff
R 500010 5ac3 0 04 00c3
R 500012 0 0 ff 005a
W 500014 1234 3 04 1
W 500016 00e7 1 00 e734
W 50001e 0015 3 01 b
R 500018 1 0 06 0011
W 400000 0 3 02 02
A 0 0 0 02 00
W 40000c 0 3 02 20
W 400004 0 3 02 21
A 0 0 0 02 00
R 400008 beef 0 05 beef
C 0 0 0 02 08
A 0 0 0 02 00
W 5000c6 0 3 03 3
C 0 0 0 02 40
A 0 0 0 02 00
R 300000 0 0 ff 0

/* list.f */
+incdir+hw
hw/bus_map_pkg.sv
hw/board_io_pkg.sv
hw/cpu_bus_if.sv
hw/cen_divider.sv
hw/access_fsm.sv
hw/work_ram.sv
hw/io_ports.sv
hw/gcu_strobes.sv
hw/bakraid_bus_top.sv
testbench/tb_bakraid_bus.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_bakraid_bus ||
    { echo "build failed"; exit 1; }
./obj_dir/Vtb_bakraid_bus > sim.log 2>&1
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test passed" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
